// ==== design/tetris_pkg.sv ====
// Line scoring shared types
package tetris_pkg;

    localparam int BOARD_COLS = 10;
    localparam int ROW_IDX_W  = 5;

    // one bit per column, bit 0 is the leftmost column.
    typedef logic [BOARD_COLS-1:0] row_t;

    // cells[0] lands on base_row and cells[3] on base_row+3.
    typedef struct packed {
        logic                 valid;
        logic                 tspin;
        logic [ROW_IDX_W-1:0] base_row;
        row_t [3:0]           cells;
    } lock_t;

    typedef struct packed {
        logic [9:0] lines_cleared;
        logic [9:0] lines_sent;
        logic [4:0] combo_count;
    } line_stats_t;

    typedef struct packed {
        logic       valid;
        logic [9:0] lines_sent_new;
    } attack_t;

    // garbage lines earned by the clear itself, before combo and back-to-back.
    function automatic logic [9:0] base_attack(input logic [9:0] count, input logic tspin);
        logic [9:0] result;
        if (tspin) begin
            result = (count << 1) + 10'd1;
        end else begin
            case (count)
                10'd2:   result = 10'd1;
                10'd3:   result = 10'd2;
                10'd4:   result = 10'd4;
                default: result = 10'd0;
            endcase
        end
        return result;
    endfunction

    function automatic logic [9:0] combo_bonus(input logic [4:0] combo);
        logic [9:0] result;
        if (combo == 5'd0) begin
            result = 10'd0;
        end else if (combo < 5'd3) begin
            result = 10'd1;
        end else if (combo < 5'd5) begin
            result = 10'd2;
        end else if (combo < 5'd7) begin
            result = 10'd3;
        end else if (combo < 5'd10) begin
            result = 10'd4;
        end else begin
            result = 10'd5;
        end
        return result;
    endfunction

endpackage

// ==== design/board_rows.sv ====
// Board occupancy grid
module board_rows
    import tetris_pkg::*;
#(
    parameter int ROWS = 20
) (
    input  logic            clk,
    input  logic            rst_l,
    input  logic            game_start,
    input  lock_t           lock,
    output logic [ROWS-1:0] full_rows,
    output logic            scored,
    output logic            scored_tspin
);
    // row 0 is the bottom of the board.
    row_t grid      [ROWS];
    row_t merged    [ROWS];
    row_t collapsed [ROWS];

    logic [ROWS-1:0]      merged_full;
    logic [ROW_IDX_W-1:0] drop [ROWS];

    // The grid as it will look once the locked piece is ORed in.
    // Piece rows that land at or above ROWS simply match no grid row.
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            merged[r] = grid[r];
            for (int k = 0; k < 4; k++) begin
                if (lock.valid && (int'(lock.base_row) + k == r)) begin
                    merged[r] = merged[r] | lock.cells[k];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            merged_full[r] = &merged[r];
        end
    end

    // Each row falls by the number of full rows beneath it.
    always_comb begin
        drop[0] = '0;
        for (int s = 1; s < ROWS; s++) begin
            drop[s] = drop[s-1] + ROW_IDX_W'(full_rows[s-1]);
        end
    end

    // Surviving rows are written to their new position in one step.
    // Rows left over at the top stay empty.
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            collapsed[r] = '0;
        end
        for (int s = 0; s < ROWS; s++) begin
            if (!full_rows[s]) begin
                collapsed[s - int'(drop[s])] = grid[s];
            end
        end
    end

    // The collapse takes priority over a lock.
    // A lock in the scoring cycle breaks the spacing rule of the interface.
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            grid <= '{default: '0};
        end else if (game_start) begin
            grid <= '{default: '0};
        end else if (scored) begin
            grid <= collapsed;
        end else if (lock.valid) begin
            grid <= merged;
        end
    end

    // the full-row mask is only nonzero during the scoring cycle.
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            full_rows    <= '0;
            scored       <= 1'b0;
            scored_tspin <= 1'b0;
        end else if (game_start) begin
            full_rows    <= '0;
            scored       <= 1'b0;
            scored_tspin <= 1'b0;
        end else begin
            full_rows    <= lock.valid ? merged_full : '0;
            scored       <= lock.valid;
            scored_tspin <= lock.valid & lock.tspin;
        end
    end

endmodule

// ==== design/lines_manager.sv ====
// Line scoring and attack logic
module lines_manager
    import tetris_pkg::*;
#(
    parameter int ROWS = 20
) (
    input  logic            clk,
    input  logic            rst_l,
    input  logic            game_start,
    input  logic            scored,
    input  logic            scored_tspin,
    input  logic [ROWS-1:0] full_rows,
    output line_stats_t     stats,
    output attack_t         attack
);
    typedef enum logic {COMBO_BREAK, COMBO_RUN} combo_state_t;
    typedef enum logic {B2B_NONE, B2B_ACTIVE} b2b_state_t;

    combo_state_t combo_state;
    b2b_state_t   b2b_state;

    logic [9:0] lines_cleared;
    logic [9:0] lines_sent;
    logic [4:0] combo_count;

    logic [9:0] clear_count;
    logic       any_clear;
    logic [9:0] b2b_bonus;
    logic [9:0] sent_total;

    // the combo decision is made one cycle after the scoring strobe.
    logic check_q;
    logic cleared_q;

    always_comb begin
        clear_count = '0;
        for (int i = 0; i < ROWS; i++) begin
            clear_count = clear_count + 10'(full_rows[i]);
        end
    end

    assign any_clear = scored && (clear_count != 10'd0);

    assign b2b_bonus  = (b2b_state == B2B_ACTIVE) ? 10'd1 : 10'd0;
    assign sent_total = lines_sent + base_attack(clear_count, scored_tspin)
                      + combo_bonus(combo_count) + b2b_bonus;

    assign attack.valid          = any_clear && (sent_total != lines_sent);
    assign attack.lines_sent_new = sent_total;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            lines_cleared <= '0;
        end else if (game_start) begin
            lines_cleared <= '0;
        end else if (scored) begin
            lines_cleared <= lines_cleared + clear_count;
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            lines_sent <= '0;
        end else if (game_start) begin
            lines_sent <= '0;
        end else if (any_clear) begin
            lines_sent <= sent_total;
        end
    end

    // Four-line clears and T-spins arm the bonus for the next lock.
    // Every other lock disarms it.
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            b2b_state <= B2B_NONE;
        end else if (game_start) begin
            b2b_state <= B2B_NONE;
        end else if (scored) begin
            if ((clear_count == 10'd4) || scored_tspin) begin
                b2b_state <= B2B_ACTIVE;
            end else begin
                b2b_state <= B2B_NONE;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            check_q   <= 1'b0;
            cleared_q <= 1'b0;
        end else if (game_start) begin
            check_q   <= 1'b0;
            cleared_q <= 1'b0;
        end else begin
            check_q   <= scored;
            cleared_q <= any_clear;
        end
    end

    // A clear after a break only enters the combo state.
    // The counter starts to move on the second clear in a row.
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            combo_state <= COMBO_BREAK;
            combo_count <= '0;
        end else if (game_start) begin
            combo_state <= COMBO_BREAK;
            combo_count <= '0;
        end else if (check_q) begin
            if (cleared_q) begin
                combo_state <= COMBO_RUN;
                if ((combo_state == COMBO_RUN) && (combo_count != 5'd31)) begin
                    combo_count <= combo_count + 5'd1;
                end
            end else begin
                combo_state <= COMBO_BREAK;
                combo_count <= '0;
            end
        end
    end

    assign stats.lines_cleared = lines_cleared;
    assign stats.lines_sent    = lines_sent;
    assign stats.combo_count   = combo_count;

endmodule

// ==== design/lines_top.sv ====
// Line scoring top level
module lines_top
    import tetris_pkg::*;
#(
    parameter int ROWS = 20
) (
    input  logic        clk,
    input  logic        rst_l,
    input  logic        game_start,
    input  lock_t       lock,
    output line_stats_t stats,
    output attack_t     attack
);
    // full_rows is only nonzero while scored is high.
    logic [ROWS-1:0] full_rows;
    logic            scored;
    logic            scored_tspin;

    board_rows #(
        .ROWS         (ROWS)
    ) board_rows_inst (
        .clk          (clk),
        .rst_l        (rst_l),
        .game_start   (game_start),
        .lock         (lock),
        .full_rows    (full_rows),
        .scored       (scored),
        .scored_tspin (scored_tspin)
    );

    lines_manager #(
        .ROWS         (ROWS)
    ) lines_manager_inst (
        .clk          (clk),
        .rst_l        (rst_l),
        .game_start   (game_start),
        .scored       (scored),
        .scored_tspin (scored_tspin),
        .full_rows    (full_rows),
        .stats        (stats),
        .attack       (attack)
    );

endmodule

// ==== bench/lines_properties.sv ====
// Line scoring assertions
module lines_properties
    import tetris_pkg::*;
(
    input logic        clk,
    input logic        rst_l,
    input logic        game_start,
    input lock_t       lock,
    input logic        scored,
    input line_stats_t stats,
    input attack_t     attack
);
    timeunit 1ns;
    timeprecision 1ps;

    // the grid collapses during the scoring cycle, so no piece may lock then.
    lock_spacing: assert property (
        @(posedge clk) disable iff (!rst_l) scored |-> !lock.valid
    ) else $error("lock strobe arrived while scored was high");

    // an attack belongs to the scoring cycle that follows a lock strobe.
    attack_in_scoring: assert property (
        @(posedge clk) disable iff (!rst_l) attack.valid |-> scored && $past(lock.valid)
    ) else $error("attack pulse outside a scoring cycle");

    // Only a new game may bring the sent total back down.
    sent_monotonic: assert property (
        @(posedge clk) disable iff (!rst_l)
        !game_start |=> (stats.lines_sent >= $past(stats.lines_sent))
    ) else $error("lines_sent decreased without game_start");

endmodule

bind lines_top lines_properties lines_properties_inst (
    .clk        (clk),
    .rst_l      (rst_l),
    .game_start (game_start),
    .lock       (lock),
    .scored     (scored),
    .stats      (stats),
    .attack     (attack)
);

// ==== bench/tb_lines_top.sv ====
// Line scoring testbench
module tb_lines_top
    import tetris_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROWS        = 20;
    localparam int CLK_PERIOD  = 20;
    localparam int N_DIRECTED  = 48;
    localparam int N_RANDOM    = 300;
    localparam int WATCHDOG_NS = ((N_DIRECTED + N_RANDOM) * 4 + 200) * CLK_PERIOD;

    localparam row_t FULL = 10'h3ff;
    localparam row_t GAP  = 10'h3fe;
    localparam row_t COL0 = 10'h001;
    localparam row_t MARK = 10'h155;

    logic        clk;
    logic        rst_l;
    logic        game_start;
    lock_t       lock;
    line_stats_t stats;
    attack_t     attack;

    // reference model state
    row_t        m_grid [ROWS];
    line_stats_t m_stats;
    logic        m_run;
    logic        m_b2b;

    // expected results, each tagged with the cycle in which it is due.
    int          attack_due [$];
    attack_t     attack_exp [$];
    int          stats_due  [$];
    line_stats_t stats_exp  [$];

    int cyc           = 0;
    int stats_errors  = 0;
    int attack_errors = 0;
    int clear_events  = 0;

    lines_top #(
        .ROWS       (ROWS)
    ) DUT (
        .clk        (clk),
        .rst_l      (rst_l),
        .game_start (game_start),
        .lock       (lock),
        .stats      (stats),
        .attack     (attack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic void reset_model();
        for (int r = 0; r < ROWS; r++) begin
            m_grid[r] = '0;
        end
        m_stats = '0;
        m_run   = 1'b0;
        m_b2b   = 1'b0;
    endfunction

    // Merges the piece, removes full rows and applies the scoring rules.
    function automatic int model_lock(input lock_t l, output attack_t exp_att,
                                      output line_stats_t exp_st);
        row_t       kept [ROWS];
        int         count;
        int         dst;
        logic [9:0] total;
        count = 0;
        dst   = 0;
        for (int k = 0; k < 4; k++) begin
            if (int'(l.base_row) + k < ROWS) begin
                m_grid[int'(l.base_row) + k] = m_grid[int'(l.base_row) + k] | l.cells[k];
            end
        end
        for (int r = 0; r < ROWS; r++) begin
            kept[r] = '0;
        end
        for (int r = 0; r < ROWS; r++) begin
            if (&m_grid[r]) begin
                count++;
            end else begin
                kept[dst] = m_grid[r];
                dst++;
            end
        end
        m_grid = kept;
        total = m_stats.lines_sent + base_attack(10'(count), l.tspin)
              + combo_bonus(m_stats.combo_count) + (m_b2b ? 10'd1 : 10'd0);
        exp_att.valid          = (count > 0) && (total != m_stats.lines_sent);
        exp_att.lines_sent_new = total;
        m_stats.lines_cleared  = m_stats.lines_cleared + 10'(count);
        if (count > 0) begin
            m_stats.lines_sent = total;
        end
        m_b2b = (count == 4) || l.tspin;
        if (count > 0) begin
            if (m_run && (m_stats.combo_count != 5'd31)) begin
                m_stats.combo_count = m_stats.combo_count + 5'd1;
            end
            m_run = 1'b1;
        end else begin
            m_run               = 1'b0;
            m_stats.combo_count = '0;
        end
        exp_st = m_stats;
        return count;
    endfunction

    task automatic check_stats(input line_stats_t exp, input line_stats_t act);
        if (act !== exp) begin
            stats_errors++;
            $display("error at %0t ns: stats cleared %0d sent %0d combo %0d, expected %0d %0d %0d",
                     $time, act.lines_cleared, act.lines_sent, act.combo_count,
                     exp.lines_cleared, exp.lines_sent, exp.combo_count);
        end
    endtask

    // a quiet cycle only requires valid to be low.
    task automatic check_attack(input attack_t exp, input attack_t act);
        if ((exp.valid && (act !== exp)) || (!exp.valid && (act.valid !== 1'b0))) begin
            attack_errors++;
            $display("error at %0t ns: attack valid %b total %0d, expected valid %b total %0d",
                     $time, act.valid, act.lines_sent_new, exp.valid, exp.lines_sent_new);
        end
    endtask

    // Each lock occupies four cycles, which keeps it clear of the previous collapse.
    task automatic drop_piece(input logic [4:0] base, input row_t c0, input row_t c1,
                              input row_t c2, input row_t c3, input logic tspin);
        lock_t       l;
        attack_t     exp_att;
        line_stats_t exp_st;
        line_stats_t mid_st;
        logic [4:0]  old_combo;
        l.valid    = 1'b1;
        l.tspin    = tspin;
        l.base_row = base;
        l.cells    = {c3, c2, c1, c0};
        @(posedge clk);
        lock <= l;
        old_combo = m_stats.combo_count;
        if (model_lock(l, exp_att, exp_st) > 0) begin
            clear_events++;
        end
        mid_st             = exp_st;
        mid_st.combo_count = old_combo;
        attack_due.push_back(cyc + 2);
        attack_exp.push_back(exp_att);
        stats_due.push_back(cyc + 3);
        stats_exp.push_back(mid_st);
        stats_due.push_back(cyc + 4);
        stats_exp.push_back(exp_st);
        @(posedge clk);
        lock <= '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic restart_game();
        @(posedge clk);
        game_start <= 1'b1;
        reset_model();
        stats_due.push_back(cyc + 2);
        stats_exp.push_back('0);
        @(posedge clk);
        game_start <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // outputs are sampled on the falling edge, away from the driving edge.
    initial begin : compare
        attack_t exp_att;
        forever begin
            @(negedge clk);
            cyc     = cyc + 1;
            exp_att = '0;
            if ((attack_due.size() > 0) && (attack_due[0] == cyc)) begin
                void'(attack_due.pop_front());
                exp_att = attack_exp.pop_front();
            end
            check_attack(exp_att, attack);
            while ((stats_due.size() > 0) && (stats_due[0] == cyc)) begin
                void'(stats_due.pop_front());
                check_stats(stats_exp.pop_front(), stats);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        row_t       c [4];
        logic [4:0] base;
        logic       tspin;
        int         n;
        rst_l      = 1'b0;
        game_start = 1'b0;
        lock       = '0;
        void'($urandom(32'he6b3_8dba));
        reset_model();
        repeat (5) @(posedge clk);
        rst_l <= 1'b1;
        repeat (2) @(posedge clk);

        // clears of one to four rows; the marker row only completes if it fell.
        for (int k = 1; k <= 4; k++) begin
            drop_piece(5'(k), MARK, '0, '0, '0, 1'b0);
            drop_piece(5'd0, GAP, (k > 1) ? GAP : '0, (k > 2) ? GAP : '0,
                       (k > 3) ? GAP : '0, 1'b0);
            drop_piece(5'd0, COL0, (k > 1) ? COL0 : '0, (k > 2) ? COL0 : '0,
                       (k > 3) ? COL0 : '0, 1'b0);
            drop_piece(5'd0, ~MARK, '0, '0, '0, 1'b0);
        end

        // a long combo runs the bonus past ten, then a miss breaks it.
        restart_game();
        for (int i = 0; i < 14; i++) begin
            drop_piece(5'd0, FULL, '0, '0, '0, 1'b0);
        end
        drop_piece(5'd2, COL0, '0, '0, '0, 1'b0);
        drop_piece(5'd0, FULL, '0, '0, '0, 1'b0);
        drop_piece(5'd0, FULL, '0, '0, '0, 1'b0);

        restart_game();
        drop_piece(5'd0, FULL, FULL, FULL, FULL, 1'b0);
        drop_piece(5'd0, FULL, FULL, FULL, FULL, 1'b0);
        drop_piece(5'd0, FULL, '0, '0, '0, 1'b0);
        drop_piece(5'd0, FULL, FULL, FULL, FULL, 1'b0);

        restart_game();
        drop_piece(5'd0, FULL, FULL, '0, '0, 1'b1);
        drop_piece(5'd0, FULL, '0, '0, '0, 1'b1);
        drop_piece(5'd0, FULL, FULL, FULL, FULL, 1'b0);
        drop_piece(5'd4, COL0, '0, '0, '0, 1'b1);

        // the gap row at row 4 would complete the row left over from the last game.
        restart_game();
        drop_piece(5'd3, COL0, GAP, '0, '0, 1'b0);
        drop_piece(5'd0, GAP, '0, '0, '0, 1'b0);
        drop_piece(5'd0, COL0, '0, '0, '0, 1'b0);
        drop_piece(5'd0, FULL, FULL, '0, '0, 1'b0);

        // Periodic restarts keep the 10-bit sent total from wrapping.
        for (int i = 0; i < N_RANDOM; i++) begin
            if ((i % 64) == 0) begin
                restart_game();
            end
            tspin = ($urandom % 8) == 0;
            case ($urandom % 3)
                0: begin
                    base = 5'($urandom % 24);
                    for (int k = 0; k < 4; k++) begin
                        c[k] = '0;
                    end
                end
                1: begin
                    base = 5'($urandom % 24);
                    for (int k = 0; k < 4; k++) begin
                        c[k] = 10'($urandom) & 10'($urandom) & 10'($urandom);
                    end
                end
                default: begin
                    base = 5'($urandom % ROWS);
                    n    = 1 + ($urandom % 4);
                    for (int k = 0; k < 4; k++) begin
                        c[k] = ((k < n) && (int'(base) + k < ROWS)) ? ~m_grid[int'(base) + k] : '0;
                    end
                end
            endcase
            drop_piece(base, c[0], c[1], c[2], c[3], tspin);
        end

        repeat (4) @(posedge clk);
        $display("%0d clearing locks, %0d stats errors, %0d attack errors",
                 clear_events, stats_errors, attack_errors);
        if ((stats_errors == 0) && (attack_errors == 0)) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/tetris_pkg.sv
design/board_rows.sv
design/lines_manager.sv
design/lines_top.sv
bench/lines_properties.sv
bench/tb_lines_top.sv

// ==== Bender.yml ====
package:
  name: lines_scoring

sources:
  # RTL in compile order
  - design/tetris_pkg.sv
  - design/board_rows.sv
  - design/lines_manager.sv
  - design/lines_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - bench/lines_properties.sv
      - bench/tb_lines_top.sv
